/* csr_pkg.sv */
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int XLEN       = 32;

    // field widths
    localparam int PLV_W      = 2;
    localparam int DAT_W      = 2;
    localparam int SWI_W      = 2;
    localparam int HWI_W      = 9;
    localparam int IS_W       = 13;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECTL,
        SEL_ESTAT,
        SEL_ERA,
        SEL_EENTRY,
        SEL_SAVE0,
        SEL_SAVE1,
        SEL_SAVE2,
        SEL_SAVE3,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR
    } csr_sel_e;

    localparam logic [CSR_ADDR_W-1:0] ADDR_CRMD   = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] ADDR_PRMD   = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ECTL   = 14'h4;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ESTAT  = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ERA    = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] ADDR_EENTRY = 14'hc;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE0  = 14'h30;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE1  = 14'h31;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE2  = 14'h32;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE3  = 14'h33;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TCFG   = 14'h41;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TVAL   = 14'h42;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TICLR  = 14'h44;

    // field positions
    localparam int CRMD_PLV_LO       = 0;
    localparam int CRMD_IE           = 2;
    localparam int CRMD_DA           = 3;
    localparam int CRMD_PG           = 4;
    localparam int CRMD_DATF_LO      = 5;
    localparam int CRMD_DATM_LO      = 7;
    localparam int PRMD_PPLV_LO      = 0;
    localparam int PRMD_PIE          = 2;
    localparam int ECTL_LIE_LO       = 0;
    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_SWI_LO      = 0;
    localparam int ESTAT_HWI_LO      = 2;
    localparam int ESTAT_TI          = 11;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int EENTRY_VA_LO      = 6;
    localparam int TCFG_EN           = 0;
    localparam int TCFG_PERIODIC     = 1;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TICLR_CLR         = 0;

    localparam logic [XLEN-1:0] CRMD_RST = XLEN'(1) << CRMD_DA;

    // writable bits per register, everything else reads zero
    localparam logic [XLEN-1:0] CRMD_WMASK =
        (XLEN'((1 << PLV_W) - 1) << CRMD_PLV_LO) | (XLEN'(1) << CRMD_IE) |
        (XLEN'(1) << CRMD_DA) | (XLEN'(1) << CRMD_PG) |
        (XLEN'((1 << DAT_W) - 1) << CRMD_DATF_LO) |
        (XLEN'((1 << DAT_W) - 1) << CRMD_DATM_LO);
    localparam logic [XLEN-1:0] PRMD_WMASK =
        (XLEN'((1 << PLV_W) - 1) << PRMD_PPLV_LO) | (XLEN'(1) << PRMD_PIE);
    localparam logic [XLEN-1:0] ECTL_WMASK   = XLEN'((1 << IS_W) - 1) << ECTL_LIE_LO;
    localparam logic [XLEN-1:0] EENTRY_WMASK = {XLEN{1'b1}} << EENTRY_VA_LO;
    // INITVAL in place is the reload value times four
    localparam logic [XLEN-1:0] TCFG_INITVAL_MASK = {XLEN{1'b1}} << TCFG_INITVAL_LO;

    function automatic csr_sel_e addr_to_sel(input logic [CSR_ADDR_W-1:0] addr);
        csr_sel_e sel;
        case (addr)
            ADDR_CRMD:   sel = SEL_CRMD;
            ADDR_PRMD:   sel = SEL_PRMD;
            ADDR_ECTL:   sel = SEL_ECTL;
            ADDR_ESTAT:  sel = SEL_ESTAT;
            ADDR_ERA:    sel = SEL_ERA;
            ADDR_EENTRY: sel = SEL_EENTRY;
            ADDR_SAVE0:  sel = SEL_SAVE0;
            ADDR_SAVE1:  sel = SEL_SAVE1;
            ADDR_SAVE2:  sel = SEL_SAVE2;
            ADDR_SAVE3:  sel = SEL_SAVE3;
            ADDR_TCFG:   sel = SEL_TCFG;
            ADDR_TVAL:   sel = SEL_TVAL;
            ADDR_TICLR:  sel = SEL_TICLR;
            default:     sel = SEL_NONE;
        endcase
        return sel;
    endfunction

endpackage

/* csr_props.sv */
module csr_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     excp_flush_i,
    input logic                     has_int_o,
    input logic [csr_pkg::PLV_W-1:0] plv_o,
    input logic [csr_pkg::XLEN-1:0] rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // pipeline must see kernel mode while the flush is in flight
    flush_plv_zero: assert property (
        @(posedge clk) disable iff (rst)
        excp_flush_i |-> (plv_o == '0)
    ) else $error("plv_o is not zero in an exception flush cycle");

    // first cycle out of reset
    no_int_after_rst: assert property (
        @(posedge clk)
        $fell(rst) |-> !has_int_o
    ) else $error("has_int_o is high in the first cycle after reset");

    rdata_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(rdata_o)
    ) else $error("rdata_o has unknown bits after reset");

endmodule

bind csr_top csr_props u_props (
    .clk          (clk),
    .rst          (rst),
    .excp_flush_i (excp_flush_i),
    .has_int_o    (has_int_o),
    .plv_o        (plv_o),
    .rdata_o      (rdata_o)
);

/* csr_read_port.sv */
module csr_read_port (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,

    input  logic                           wr_en_i,
    input  csr_pkg::csr_sel_e              wr_sel_i,
    input  logic [csr_pkg::XLEN-1:0]       wr_data_i,
    input  logic                           excp_flush_i,
    input  logic                           ertn_flush_i,

    csr_view_if.reader                     view,

    output logic [csr_pkg::XLEN-1:0]       rdata_o,
    output logic                           has_int_o,
    output logic [csr_pkg::PLV_W-1:0]      plv_o,
    output logic [csr_pkg::XLEN-1:0]       eentry_o,
    output logic [csr_pkg::XLEN-1:0]       era_o
);
    import csr_pkg::*;

    logic wr_crmd;

    // ticlr has no storage and reads zero
    always_comb begin
        case (addr_to_sel(raddr_i))
            SEL_CRMD:   rdata_o = view.crmd;
            SEL_PRMD:   rdata_o = view.prmd;
            SEL_ECTL:   rdata_o = view.ectl;
            SEL_ESTAT:  rdata_o = view.estat;
            SEL_ERA:    rdata_o = view.era;
            SEL_EENTRY: rdata_o = view.eentry;
            SEL_SAVE0:  rdata_o = view.save0;
            SEL_SAVE1:  rdata_o = view.save1;
            SEL_SAVE2:  rdata_o = view.save2;
            SEL_SAVE3:  rdata_o = view.save3;
            SEL_TCFG:   rdata_o = view.tcfg;
            SEL_TVAL:   rdata_o = view.tval;
            default:    rdata_o = '0;
        endcase
    end

    assign has_int_o = view.crmd[CRMD_IE] &&
                       |(view.ectl[ECTL_LIE_LO +: IS_W] & view.estat[ESTAT_IS_LO +: IS_W]);

    // privilege level seen by the pipeline this cycle
    assign wr_crmd = wr_en_i && (wr_sel_i == SEL_CRMD);

    always_comb begin
        if (excp_flush_i) begin
            plv_o = '0;
        end else if (ertn_flush_i) begin
            plv_o = view.prmd[PRMD_PPLV_LO +: PLV_W];
        end else if (wr_crmd) begin
            plv_o = wr_data_i[CRMD_PLV_LO +: PLV_W];
        end else begin
            plv_o = view.crmd[CRMD_PLV_LO +: PLV_W];
        end
    end

    assign eentry_o = view.eentry;
    assign era_o    = view.era;

endmodule

/* csr_timer.sv */
module csr_timer (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wr_en_i,
    input  csr_pkg::csr_sel_e        wr_sel_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,

    csr_view_if.timer                view
);
    import csr_pkg::*;

    logic [XLEN-1:0] tcfg_q;
    logic [XLEN-1:0] tval_q;
    logic            timer_en_q;
    logic            pending_q;

    logic wr_tcfg;
    logic clr_hit;
    logic expire;

    assign wr_tcfg = wr_en_i && (wr_sel_i == SEL_TCFG);
    assign clr_hit = wr_en_i && (wr_sel_i == SEL_TICLR) && wr_data_i[TICLR_CLR];
    assign expire  = timer_en_q && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q     <= '0;
            tval_q     <= '0;
            timer_en_q <= 1'b0;
        end else if (wr_tcfg) begin
            tcfg_q     <= wr_data_i;
            tval_q     <= wr_data_i & TCFG_INITVAL_MASK;
            timer_en_q <= wr_data_i[TCFG_EN];
        end else if (expire) begin
            // one-shot parks at all ones
            timer_en_q <= tcfg_q[TCFG_PERIODIC];
            if (tcfg_q[TCFG_PERIODIC]) begin
                tval_q <= tcfg_q & TCFG_INITVAL_MASK;
            end else begin
                tval_q <= '1;
            end
        end else if (timer_en_q) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // clear beats a same-cycle expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (clr_hit) begin
            pending_q <= 1'b0;
        end else if (expire) begin
            pending_q <= 1'b1;
        end
    end

    assign view.tcfg      = tcfg_q;
    assign view.tval      = tval_q;
    assign view.timer_irq = pending_q;

endmodule

/* csr_top.sv */
module csr_top (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           wr1_en_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] wr1_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wr1_data_i,
    input  logic                           wr2_en_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] wr2_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wr2_data_i,

    input  logic                           excp_flush_i,
    input  logic                           ertn_flush_i,
    input  logic [csr_pkg::ECODE_W-1:0]    ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0] esubcode_i,
    input  logic [csr_pkg::XLEN-1:0]       era_i,
    input  logic [csr_pkg::HWI_W-1:0]      hw_int_i,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,
    output logic                           has_int_o,
    output logic [csr_pkg::PLV_W-1:0]      plv_o,
    output logic [csr_pkg::XLEN-1:0]       eentry_o,
    output logic [csr_pkg::XLEN-1:0]       era_o
);
    import csr_pkg::*;

    logic            wr_en;
    csr_sel_e        wr_sel;
    logic [XLEN-1:0] wr_data;

    csr_view_if u_view ();

    csr_wr_arbiter u_wr_arbiter (
        .clk        (clk),
        .rst        (rst),
        .wr1_en_i   (wr1_en_i),
        .wr1_addr_i (wr1_addr_i),
        .wr1_data_i (wr1_data_i),
        .wr2_en_i   (wr2_en_i),
        .wr2_addr_i (wr2_addr_i),
        .wr2_data_i (wr2_data_i),
        .wr_en_o    (wr_en),
        .wr_sel_o   (wr_sel),
        .wr_data_o  (wr_data)
    );

    csr_trap_regs u_trap_regs (
        .clk          (clk),
        .rst          (rst),
        .wr_en_i      (wr_en),
        .wr_sel_i     (wr_sel),
        .wr_data_i    (wr_data),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .hw_int_i     (hw_int_i),
        .view         (u_view.trap)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en),
        .wr_sel_i  (wr_sel),
        .wr_data_i (wr_data),
        .view      (u_view.timer)
    );

    csr_read_port u_read_port (
        .raddr_i      (raddr_i),
        .wr_en_i      (wr_en),
        .wr_sel_i     (wr_sel),
        .wr_data_i    (wr_data),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .view         (u_view.reader),
        .rdata_o      (rdata_o),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o)
    );

endmodule

/* csr_trap_regs.sv */
module csr_trap_regs (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           wr_en_i,
    input  csr_pkg::csr_sel_e              wr_sel_i,
    input  logic [csr_pkg::XLEN-1:0]       wr_data_i,

    input  logic                           excp_flush_i,
    input  logic                           ertn_flush_i,
    input  logic [csr_pkg::ECODE_W-1:0]    ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0] esubcode_i,
    input  logic [csr_pkg::XLEN-1:0]       era_i,
    input  logic [csr_pkg::HWI_W-1:0]      hw_int_i,

    csr_view_if.trap                       view
);
    import csr_pkg::*;

    logic [XLEN-1:0]       crmd_q;
    logic [XLEN-1:0]       prmd_q;
    logic [XLEN-1:0]       ectl_q;
    logic [XLEN-1:0]       era_q;
    logic [XLEN-1:0]       eentry_q;
    logic [XLEN-1:0]       save_q [4];
    logic [SWI_W-1:0]      swi_q;
    logic [HWI_W-1:0]      hwi_q;
    logic [ECODE_W-1:0]    ecode_q;
    logic [ESUBCODE_W-1:0] esubcode_q;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ectl;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    assign wr_crmd   = wr_en_i && (wr_sel_i == SEL_CRMD);
    assign wr_prmd   = wr_en_i && (wr_sel_i == SEL_PRMD);
    assign wr_ectl   = wr_en_i && (wr_sel_i == SEL_ECTL);
    assign wr_estat  = wr_en_i && (wr_sel_i == SEL_ESTAT);
    assign wr_era    = wr_en_i && (wr_sel_i == SEL_ERA);
    assign wr_eentry = wr_en_i && (wr_sel_i == SEL_EENTRY);

    // flush, then return, then plain write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RST;
        end else if (excp_flush_i) begin
            crmd_q[CRMD_PLV_LO +: PLV_W] <= '0;
            crmd_q[CRMD_IE]              <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd_q[CRMD_PLV_LO +: PLV_W] <= prmd_q[PRMD_PPLV_LO +: PLV_W];
            crmd_q[CRMD_IE]              <= prmd_q[PRMD_PIE];
        end else if (wr_crmd) begin
            crmd_q <= wr_data_i & CRMD_WMASK;
        end
    end

    // old mode saved on exception entry
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (excp_flush_i) begin
            prmd_q[PRMD_PPLV_LO +: PLV_W] <= crmd_q[CRMD_PLV_LO +: PLV_W];
            prmd_q[PRMD_PIE]              <= crmd_q[CRMD_IE];
        end else if (wr_prmd) begin
            prmd_q <= wr_data_i & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q   <= '0;
            eentry_q <= '0;
        end else begin
            if (wr_ectl) begin
                ectl_q <= wr_data_i & ECTL_WMASK;
            end
            if (wr_eentry) begin
                eentry_q <= wr_data_i & EENTRY_WMASK;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_q <= '0;
        end else if (excp_flush_i) begin
            era_q <= era_i;
        end else if (wr_era) begin
            era_q <= wr_data_i;
        end
    end

    // estat pieces; only the software bits are writable
    always_ff @(posedge clk) begin
        if (rst) begin
            swi_q      <= '0;
            hwi_q      <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hwi_q <= hw_int_i;
            if (wr_estat) begin
                swi_q <= wr_data_i[ESTAT_SWI_LO +: SWI_W];
            end
            if (excp_flush_i) begin
                ecode_q    <= ecode_i;
                esubcode_q <= esubcode_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            case (wr_sel_i)
                SEL_SAVE0: save_q[0] <= wr_data_i;
                SEL_SAVE1: save_q[1] <= wr_data_i;
                SEL_SAVE2: save_q[2] <= wr_data_i;
                SEL_SAVE3: save_q[3] <= wr_data_i;
                default:   ;
            endcase
        end
    end

    // timer pending bit lives in the timer
    always_comb begin
        view.estat                                     = '0;
        view.estat[ESTAT_SWI_LO +: SWI_W]              = swi_q;
        view.estat[ESTAT_HWI_LO +: HWI_W]              = hwi_q;
        view.estat[ESTAT_TI]                           = view.timer_irq;
        view.estat[ESTAT_ECODE_LO +: ECODE_W]          = ecode_q;
        view.estat[ESTAT_ESUBCODE_LO +: ESUBCODE_W]    = esubcode_q;
    end

    assign view.crmd   = crmd_q;
    assign view.prmd   = prmd_q;
    assign view.ectl   = ectl_q;
    assign view.era    = era_q;
    assign view.eentry = eentry_q;
    assign view.save0  = save_q[0];
    assign view.save1  = save_q[1];
    assign view.save2  = save_q[2];
    assign view.save3  = save_q[3];

endmodule

/* csr_vectors.txt */
# op f1 f2 f3 f4 f5, hex; W1/W2 addr data, WB addr1 data1 addr2 data2, EX ecode esub era
# RT plv, IRQ lines, IDLE cycles random_extra, CHK addr rdata has_int plv, TEST name
TEST reset
CHK 0 00000008 0 0
CHK 41 00000000 0 0
CHK 42 00000000 0 0
CHK 5 00000000 0 0
TEST write_masks
W1 0 ffffffff
CHK 0 000001ff 0 3
W1 0 00000008
CHK 0 00000008 0 0
W2 1 ffffffff
CHK 1 00000007 0 0
W1 4 ffffffff
CHK 4 00001fff 0 0
W2 5 ffffffff
CHK 5 00000003 0 0
W1 6 12345678
IDLE 0 1
CHK 6 12345678 0 0
W2 c ffffffff
CHK c ffffffc0 0 0
W1 30 a5a5a5a5
W2 31 5a5a5a5a
W1 32 0badf00d
W2 33 c0ffee11
IDLE 1 1
CHK 30 a5a5a5a5 0 0
CHK 31 5a5a5a5a 0 0
CHK 32 0badf00d 0 0
CHK 33 c0ffee11 0 0
W1 42 ffffffff
CHK 42 00000000 0 0
W2 100 ffffffff
CHK 100 00000000 0 0
W1 44 00000000
CHK 44 00000000 0 0
W1 4 00000000
W2 5 00000000
CHK 5 00000000 0 0
TEST port_priority
WB 30 11111111 30 22222222
CHK 30 11111111 0 0
WB 31 33333333 32 44444444
IDLE 0 1
CHK 31 33333333 0 0
CHK 32 0badf00d 0 0
TEST exception
W1 0 00000007
W2 1 00000000
CHK 0 00000007 0 3
CHK 1 00000000 0 3
EX b 1a5 1c000100
CHK 0 00000000 0 0
CHK 1 00000007 0 0
CHK 5 694b0000 0 0
CHK 6 1c000100 0 0
RT 3
CHK 0 00000007 0 3
W1 0 00000008
CHK 0 00000008 0 0
TEST timer_oneshot
W1 41 00000009
CHK 42 00000008 0 0
CHK 42 00000007 0 0
CHK 42 00000006 0 0
CHK 42 00000005 0 0
CHK 42 00000004 0 0
CHK 42 00000003 0 0
CHK 42 00000002 0 0
CHK 42 00000001 0 0
CHK 42 00000000 0 0
CHK 42 ffffffff 0 0
CHK 5 694b0800 0 0
CHK 41 00000009 0 0
IDLE 1 1
CHK 42 ffffffff 0 0
W2 44 00000001
CHK 5 694b0000 0 0
TEST timer_periodic
W1 41 00000007
CHK 42 00000004 0 0
CHK 42 00000003 0 0
CHK 42 00000002 0 0
CHK 42 00000001 0 0
CHK 42 00000000 0 0
CHK 42 00000004 0 0
CHK 5 694b0800 0 0
W2 44 00000001
CHK 5 694b0000 0 0
CHK 42 00000000 0 0
CHK 5 694b0800 0 0
W1 41 00000000
W2 44 00000001
CHK 5 694b0000 0 0
CHK 42 00000000 0 0
TEST interrupts
W1 4 00000004
IRQ 001
CHK 5 694b0004 0 0
W1 0 0000000c
CHK 0 0000000c 1 0
IRQ 000
CHK 5 694b0000 0 0
IRQ 002
CHK 5 694b0008 0 0
IRQ 000
CHK 5 694b0000 0 0
IRQ 001
CHK 5 694b0004 1 0
IRQ 000
CHK 5 694b0000 0 0
W1 4 00000800
W1 41 00000001
CHK 5 694b0000 0 0
CHK 5 694b0800 1 0
W2 44 00000001
CHK 5 694b0000 0 0
W1 4 00000001
W2 5 00000001
CHK 5 694b0001 1 0
W1 0 00000008
CHK 5 694b0001 0 0

/* csr_view_if.sv */
interface csr_view_if;
    import csr_pkg::*;

    // trap side
    logic [XLEN-1:0] crmd;
    logic [XLEN-1:0] prmd;
    logic [XLEN-1:0] ectl;
    logic [XLEN-1:0] estat;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] eentry;
    logic [XLEN-1:0] save0;
    logic [XLEN-1:0] save1;
    logic [XLEN-1:0] save2;
    logic [XLEN-1:0] save3;

    // timer side
    logic [XLEN-1:0] tcfg;
    logic [XLEN-1:0] tval;
    logic            timer_irq;

    modport trap (
        output crmd, prmd, ectl, estat, era, eentry,
        output save0, save1, save2, save3,
        input  timer_irq
    );

    modport timer (
        output tcfg, tval, timer_irq
    );

    modport reader (
        input crmd, prmd, ectl, estat, era, eentry,
        input save0, save1, save2, save3,
        input tcfg, tval, timer_irq
    );

endinterface

/* csr_wr_arbiter.sv */
module csr_wr_arbiter (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           wr1_en_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] wr1_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wr1_data_i,
    input  logic                           wr2_en_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] wr2_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wr2_data_i,

    output logic                           wr_en_o,
    output csr_pkg::csr_sel_e              wr_sel_o,
    output logic [csr_pkg::XLEN-1:0]       wr_data_o
);
    import csr_pkg::*;

    logic                  pick_en;
    logic [CSR_ADDR_W-1:0] pick_addr;
    csr_sel_e              pick_sel;

    // port 1 wins whenever it is enabled
    always_comb begin
        if (wr1_en_i) begin
            pick_en   = 1'b1;
            pick_addr = wr1_addr_i;
            wr_data_o = wr1_data_i;
        end else begin
            pick_en   = wr2_en_i;
            pick_addr = wr2_addr_i;
            wr_data_o = wr2_data_i;
        end
    end

    // tval is read-only
    always_comb begin
        pick_sel = addr_to_sel(pick_addr);
        if (pick_sel == SEL_TVAL) begin
            wr_sel_o = SEL_NONE;
        end else begin
            wr_sel_o = pick_sel;
        end
    end

    assign wr_en_o = pick_en && (wr_sel_o != SEL_NONE);

endmodule

/* sim.f */
csr_pkg.sv
csr_view_if.sv
csr_wr_arbiter.sv
csr_trap_regs.sv
csr_timer.sv
csr_read_port.sv
csr_top.sv
csr_props.sv
tb_csr.sv

/* tb_csr.sv */
module tb_csr;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam int RST_CYCLES      = 16;
    localparam int MAX_LINES       = 1000;
    localparam int MAX_IDLE        = 64;
    localparam int WATCHDOG_CYCLES = 5000;

    logic                  clk;
    logic                  rst;
    logic                  wr1_en_i;
    logic [CSR_ADDR_W-1:0] wr1_addr_i;
    logic [XLEN-1:0]       wr1_data_i;
    logic                  wr2_en_i;
    logic [CSR_ADDR_W-1:0] wr2_addr_i;
    logic [XLEN-1:0]       wr2_data_i;
    logic                  excp_flush_i;
    logic                  ertn_flush_i;
    logic [ECODE_W-1:0]    ecode_i;
    logic [ESUBCODE_W-1:0] esubcode_i;
    logic [XLEN-1:0]       era_i;
    logic [HWI_W-1:0]      hw_int_i;
    logic [CSR_ADDR_W-1:0] raddr_i;
    logic [XLEN-1:0]       rdata_o;
    logic                  has_int_o;
    logic [PLV_W-1:0]      plv_o;
    logic [XLEN-1:0]       eentry_o;
    logic [XLEN-1:0]       era_o;

    reg [8*128-1:0] line;
    reg [8*16-1:0]  op;
    reg [8*32-1:0]  test_name;
    logic [31:0]    f1, f2, f3, f4;
    logic [31:0]    lcg_state;
    int             test_count;
    int             check_count;
    int             error_count;
    int             test_checks;
    int             test_errors;

    csr_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .wr1_en_i     (wr1_en_i),
        .wr1_addr_i   (wr1_addr_i),
        .wr1_data_i   (wr1_data_i),
        .wr2_en_i     (wr2_en_i),
        .wr2_addr_i   (wr2_addr_i),
        .wr2_data_i   (wr2_data_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .hw_int_i     (hw_int_i),
        .raddr_i      (raddr_i),
        .rdata_o      (rdata_o),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic release_strobes();
        wr1_en_i     = 1'b0;
        wr2_en_i     = 1'b0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        int i;
        if (n > MAX_IDLE) begin
            $display("idle count %0d is above the limit of %0d cycles", n, MAX_IDLE);
            error_count++;
            test_errors++;
            n = MAX_IDLE;
        end
        for (i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        test_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0s %0s expected %h actual %h", test_name, what, exp, act);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_name != 0) begin
            test_count++;
            if (test_errors == 0) begin
                $display("test %0s: %0d checks, ok", test_name, test_checks);
            end else begin
                $display("test %0s: %0d checks, %0d errors", test_name, test_checks,
                         test_errors);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // one vector line; every operation but IDLE takes one cycle
    task automatic apply_vector();
        int extra;
        extra = 0;
        release_strobes();
        case (op)
            "W1": begin
                wr1_en_i   = 1'b1;
                wr1_addr_i = f1[CSR_ADDR_W-1:0];
                wr1_data_i = f2;
                next_cycle();
            end
            "W2": begin
                wr2_en_i   = 1'b1;
                wr2_addr_i = f1[CSR_ADDR_W-1:0];
                wr2_data_i = f2;
                next_cycle();
            end
            "WB": begin
                wr1_en_i   = 1'b1;
                wr1_addr_i = f1[CSR_ADDR_W-1:0];
                wr1_data_i = f2;
                wr2_en_i   = 1'b1;
                wr2_addr_i = f3[CSR_ADDR_W-1:0];
                wr2_data_i = f4;
                next_cycle();
            end
            "EX": begin
                excp_flush_i = 1'b1;
                ecode_i      = f1[ECODE_W-1:0];
                esubcode_i   = f2[ESUBCODE_W-1:0];
                era_i        = f3;
                #4;
                check_value("plv_o in flush cycle", 32'd0, {30'd0, plv_o});
                next_cycle();
            end
            "RT": begin
                ertn_flush_i = 1'b1;
                #4;
                check_value("plv_o in return cycle", f1, {30'd0, plv_o});
                next_cycle();
            end
            "IRQ": begin
                hw_int_i = f1[HWI_W-1:0];
                next_cycle();
            end
            "IDLE": begin
                if (f2 != 0) begin
                    lcg_state = lcg_next(lcg_state);
                    extra     = int'(lcg_state[17:16]);
                end
                idle_cycles(int'(f1) + extra);
            end
            "CHK": begin
                raddr_i = f1[CSR_ADDR_W-1:0];
                #4;
                check_value("rdata_o", f2, rdata_o);
                check_value("has_int_o", f3, {31'd0, has_int_o});
                check_value("plv_o", f4, {30'd0, plv_o});
                // era and eentry also leave the top level directly
                if (f1[CSR_ADDR_W-1:0] == ADDR_ERA) begin
                    check_value("era_o", f2, era_o);
                end
                if (f1[CSR_ADDR_W-1:0] == ADDR_EENTRY) begin
                    check_value("eentry_o", f2, eentry_o);
                end
                next_cycle();
            end
            default: begin
                $display("unknown operation %0s in the vector file", op);
                error_count++;
                test_errors++;
            end
        endcase
    endtask

    initial begin
        int fd;
        int code;
        int nfields;
        int lines;
        int i;
        rst          = 1'b1;
        wr1_en_i     = 1'b0;
        wr1_addr_i   = '0;
        wr1_data_i   = '0;
        wr2_en_i     = 1'b0;
        wr2_addr_i   = '0;
        wr2_data_i   = '0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        ecode_i      = '0;
        esubcode_i   = '0;
        era_i        = '0;
        hw_int_i     = '0;
        raddr_i      = '0;
        lcg_state    = 32'h492b4895;
        test_name    = 0;
        test_count   = 0;
        check_count  = 0;
        error_count  = 0;
        test_checks  = 0;
        test_errors  = 0;

        for (i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;

        fd = $fopen("csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open csr_vectors.txt");
            error_count++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                line = 0;
                op   = 0;
                f1   = 0;
                f2   = 0;
                f3   = 0;
                f4   = 0;
                code = $fgets(line, fd);
                lines++;
                nfields = $sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4);
                if (code == 0 || op == 0 || op == "#") begin
                    // blank or comment line
                end else if (op == "TEST") begin
                    finish_test();
                    nfields = $sscanf(line, "%s %s", op, test_name);
                    if (nfields != 2) begin
                        $display("test line %0d in the vector file has no name", lines);
                        error_count++;
                    end
                end else begin
                    apply_vector();
                end
            end
            if (!$feof(fd)) begin
                $display("vector file has more than %0d lines", MAX_LINES);
                error_count++;
            end
            $fclose(fd);
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        int n;
        for (n = 0; n < WATCHDOG_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("timeout, vector replay did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule
